// File: Makefile
# Verilator flow for the branch predictor front end
TOP = bp_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f src.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bp_assert.sv
`timescale 1ns/1ns

module bp_assert (
	input logic clk,
	input logic reset_n,
	input logic resolve_en,
	input logic resolve_valid,
	input logic full,
	input logic flush,
	input bp_pkg::pc_t fetch_pc,
	input bp_pkg::pc_t redirect_pc
);

	// a redirect restarts fetch at redirect_pc with nothing left in flight
	a_flush_redirects: assert property (@(posedge clk) disable iff (!reset_n)
		flush |=> (fetch_pc == $past(redirect_pc)) && !resolve_valid)
		else $error("fetch did not restart at redirect_pc with an empty queue");

	// pc register holds while the queue is full
	a_fetch_holds: assert property (@(posedge clk) disable iff (!reset_n)
		(full && !flush) |=> (fetch_pc == $past(fetch_pc)))
		else $error("fetch_pc moved while the queue was full");

	// resolve needs an entry to retire
	a_resolve_has_entry: assert property (@(posedge clk) disable iff (!reset_n)
		resolve_en |-> resolve_valid)
		else $error("resolve_en raised with an empty queue");

endmodule

// File: bp_checker.sv
`timescale 1ns/1ns

module bp_checker #(
	parameter int idx_bits = 4,
	parameter int queue_depth = 4
) (
	input logic clk,
	input logic reset_n,
	input logic resolve_en,
	input logic is_branch,
	input logic actual_taken,
	input bp_pkg::pc_t actual_target,
	input bp_pkg::pc_t fetch_pc,
	input logic fetch_valid,
	input logic resolve_valid,
	input bp_pkg::pc_t resolve_pc,
	input logic flush,
	input bp_pkg::pc_t redirect_pc,
	output int errors,
	output int checks
);

	import bp_pkg::*;

	localparam int entries = 1 << idx_bits;

	// predictor model
	logic m_valid [entries];
	logic [1:0] m_cnt [entries];
	pc_t m_tag [entries];
	pc_t m_target [entries];
	// fetch and queue model
	pc_t m_pc;
	pc_t q_pc [$];
	pc_t q_next [$];
	logic ready = 1'b0;

	task compare_value(input string name, input pc_t got, input pc_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// outputs are settled at the falling edge, inputs were driven after the rising one
	always @(negedge clk) begin : model
		int idx;
		int t_idx;
		logic has_head;
		logic p_taken;
		pc_t p_next;
		pc_t a_next;
		logic e_flush;
		logic e_fetch;
		if (!reset_n) begin
			if (!ready) begin
				errors = 0;
				checks = 0;
			end
			ready = 1'b1;
			m_pc = '0;
			q_pc.delete();
			q_next.delete();
			for (int i = 0; i < entries; i++) begin
				m_valid[i] = 1'b0;
				m_cnt[i] = 2'd0;
			end
		end else if (ready) begin
			// prediction for the pc being fetched
			idx = m_pc % entries;
			p_taken = m_valid[idx] && (m_tag[idx] == (m_pc >> idx_bits)) && (m_cnt[idx] >= 2);
			p_next = p_taken ? m_target[idx] : m_pc + 16'd1;
			has_head = (q_pc.size() != 0);
			compare_value("resolve_valid", resolve_valid, has_head);
			if (has_head) begin
				compare_value("resolve_pc", resolve_pc, q_pc[0]);
			end
			// resolution of the oldest entry
			e_flush = 1'b0;
			a_next = '0;
			if (resolve_en && has_head) begin
				a_next = (is_branch && actual_taken) ? actual_target : q_pc[0] + 16'd1;
				e_flush = (a_next != q_next[0]);
			end
			compare_value("flush", flush, e_flush);
			if (e_flush) begin
				compare_value("redirect_pc", redirect_pc, a_next);
			end
			e_fetch = (q_pc.size() < queue_depth) && !e_flush;
			compare_value("fetch_valid", fetch_valid, e_fetch);
			compare_value("fetch_pc", fetch_pc, m_pc);
			// training, visible from the next cycle
			if (resolve_en && has_head && is_branch) begin
				t_idx = q_pc[0] % entries;
				if (m_valid[t_idx] && (m_tag[t_idx] == (q_pc[0] >> idx_bits))) begin
					if (actual_taken && m_cnt[t_idx] != 2'd3) begin
						m_cnt[t_idx] = m_cnt[t_idx] + 2'd1;
					end else if (!actual_taken && m_cnt[t_idx] != 2'd0) begin
						m_cnt[t_idx] = m_cnt[t_idx] - 2'd1;
					end
				end else begin
					m_cnt[t_idx] = actual_taken ? 2'd2 : 2'd1;
				end
				m_valid[t_idx] = 1'b1;
				m_tag[t_idx] = q_pc[0] >> idx_bits;
				m_target[t_idx] = actual_target;
			end
			// state after the next rising edge
			if (e_flush) begin
				q_pc.delete();
				q_next.delete();
				m_pc = a_next;
			end else begin
				if (resolve_en && has_head) begin
					void'(q_pc.pop_front());
					void'(q_next.pop_front());
				end
				if (e_fetch) begin
					q_pc.push_back(m_pc);
					q_next.push_back(p_next);
					m_pc = p_next;
				end
			end
		end
	end

endmodule

// File: bp_pkg.sv
package bp_pkg;

	// instruction address width, fixed for the whole front end
	localparam int word_width = 16;

	// one instruction address
	typedef logic [word_width-1:0] pc_t;

	// per-entry 2-bit saturating branch counter
	// 0 strong not taken, 1 weak not taken
	// 2 weak taken, 3 strong taken
	typedef logic [1:0] sat_cnt_t;

	// predict taken at or above this value
	// also the start value for a newly allocated taken branch
	localparam sat_cnt_t cnt_weak_taken = 2'd2;

	// start value for a newly allocated not-taken branch
	localparam sat_cnt_t cnt_weak_not_taken = 2'd1;

endpackage

// File: bp_tb.sv
`timescale 1ns/1ns

module bp_tb;

	import bp_pkg::*;

	localparam int idx_bits = 4;
	localparam int queue_depth = 4;
	// all test lengths plus the resets between them
	localparam int total_cycles = 16 + 10 + 12 + 30 + 80 + 400 + 6 * 4;

	logic clk;
	logic reset_n;
	logic resolve_en;
	logic is_branch;
	logic actual_taken;
	pc_t actual_target;
	pc_t fetch_pc;
	logic fetch_valid;
	logic resolve_valid;
	pc_t resolve_pc;
	logic flush;
	pc_t redirect_pc;

	integer seed;
	int chk_errors;
	int chk_checks;
	int tb_errors;
	int tb_checks;
	int base_errors;
	int n_fetch;
	int n_flush;
	pc_t last_redirect;
	logic was_flush;
	// random program, indexed by the low pc bits
	logic prog_br [64];
	int prog_rate [64];
	pc_t prog_tgt [64];
	// forced outcomes for one branch pc, oldest first
	pc_t seq_pc;
	logic taken_seq [$];

	branch_predict_top #(
		.idx_bits(idx_bits),
		.queue_depth(queue_depth)
	) dut0 (
		.clk(clk),
		.reset_n(reset_n),
		.resolve_en(resolve_en),
		.is_branch(is_branch),
		.actual_taken(actual_taken),
		.actual_target(actual_target),
		.fetch_pc(fetch_pc),
		.fetch_valid(fetch_valid),
		.resolve_valid(resolve_valid),
		.resolve_pc(resolve_pc),
		.flush(flush),
		.redirect_pc(redirect_pc)
	);

	bp_checker #(
		.idx_bits(idx_bits),
		.queue_depth(queue_depth)
	) checker0 (
		.clk(clk),
		.reset_n(reset_n),
		.resolve_en(resolve_en),
		.is_branch(is_branch),
		.actual_taken(actual_taken),
		.actual_target(actual_target),
		.fetch_pc(fetch_pc),
		.fetch_valid(fetch_valid),
		.resolve_valid(resolve_valid),
		.resolve_pc(resolve_pc),
		.flush(flush),
		.redirect_pc(redirect_pc),
		.errors(chk_errors),
		.checks(chk_checks)
	);

	// full is internal to the top, so the assertions sit inside it
	bind branch_predict_top bp_assert assert0 (
		.clk(clk),
		.reset_n(reset_n),
		.resolve_en(resolve_en),
		.resolve_valid(resolve_valid),
		.full(full),
		.flush(flush),
		.fetch_pc(fetch_pc),
		.redirect_pc(redirect_pc)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// watchdog
	initial begin
		#(total_cycles * 8 + 400);
		$display("Timeout: the tests did not finish within the cycle budget");
		$display("Checks failed");
		$finish;
	end

	task clear_program;
		for (int i = 0; i < 64; i++) begin
			prog_br[i] = 1'b0;
			prog_rate[i] = 0;
			prog_tgt[i] = '0;
		end
		seq_pc = 16'hffff;
		taken_seq.delete();
	endtask

	task apply_reset;
		reset_n = 1'b0;
		resolve_en = 1'b0;
		is_branch = 1'b0;
		actual_taken = 1'b0;
		actual_target = '0;
		repeat (4) @(posedge clk);
		#1 reset_n = 1'b1;
	endtask

	// rate is the percentage of cycles with a resolve while the queue holds entries
	task run_cycles(input int cycles, input int rate);
		int r;
		int idx;
		logic tk;
		n_fetch = 0;
		n_flush = 0;
		was_flush = 1'b0;
		repeat (cycles) begin
			@(negedge clk);
			if (fetch_valid) begin
				n_fetch++;
			end
			check_that(!(was_flush && resolve_valid), "queue still held entries after a flush");
			was_flush = flush;
			if (flush) begin
				n_flush++;
				last_redirect = redirect_pc;
			end
			@(posedge clk);
			#1;
			r = $random(seed);
			idx = resolve_pc[5:0];
			resolve_en = resolve_valid && (((r & 32'h7fffffff) % 100) < rate);
			is_branch = prog_br[idx];
			actual_target = prog_tgt[idx];
			r = $random(seed);
			tk = (((r & 32'h7fffffff) % 100) < prog_rate[idx]);
			if (resolve_en && is_branch && resolve_pc == seq_pc && taken_seq.size() > 0) begin
				tk = taken_seq.pop_front();
			end
			actual_taken = tk;
		end
	endtask

	task check_that(input logic ok, input string what);
		tb_checks++;
		if (!ok) begin
			tb_errors++;
			$display("Error at %0t: %s", $time, what);
		end
	endtask

	task report_test(input string name);
		$display("test %s finished with %0d errors", name, chk_errors + tb_errors - base_errors);
		base_errors = chk_errors + tb_errors;
	endtask

	initial begin
		int r;
		seed = 32'h1953a6e4;
		tb_errors = 0;
		tb_checks = 0;
		base_errors = 0;
		clear_program();
		apply_reset();
		run_cycles(16, 100);
		check_that(n_flush == 0, "straight-line code raised a flush");
		report_test("reset and sequential fetch");
		apply_reset();
		run_cycles(10, 0);
		check_that(n_fetch == queue_depth, "fetch did not stop after queue_depth entries");
		report_test("back-pressure");
		// first-seen taken branch at 3
		apply_reset();
		prog_br[3] = 1'b1;
		prog_tgt[3] = 16'd40;
		prog_rate[3] = 100;
		run_cycles(12, 100);
		check_that(n_flush == 1 && last_redirect == 16'd40, "taken branch did not redirect once");
		report_test("misprediction redirect");
		// loop 0 to 3, only the first pass mispredicts
		apply_reset();
		prog_tgt[3] = 16'd0;
		run_cycles(30, 100);
		check_that(n_flush == 1, "a learned taken branch still flushed");
		report_test("learned prediction");
		// taken three times then not taken twice, 6 always jumps back to 0
		apply_reset();
		prog_br[6] = 1'b1;
		prog_tgt[6] = 16'd0;
		prog_rate[6] = 100;
		seq_pc = 16'd3;
		taken_seq = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
		run_cycles(80, 100);
		check_that(n_flush == 5, "counter sequence gave the wrong number of flushes");
		report_test("counter saturation");
		apply_reset();
		clear_program();
		for (int i = 0; i < 64; i++) begin
			r = $random(seed);
			prog_br[i] = (r[1:0] == 2'd0);
			prog_tgt[i] = 16'(r[13:8]);
			prog_rate[i] = r[4] ? 80 : 20;
		end
		run_cycles(400, 50);
		report_test("random program");
		$display("summary: %0d checks, %0d errors", chk_checks + tb_checks, chk_errors + tb_errors);
		if (chk_errors + tb_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: branch_predict_top.sv
`timescale 1ns/1ns

module branch_predict_top #(
	parameter int idx_bits = 4,
	parameter int queue_depth = 4
) (
	input logic clk,
	input logic reset_n,
	// resolve strobe and outcome of the oldest instruction
	input logic resolve_en,
	input logic is_branch,
	input logic actual_taken,
	input bp_pkg::pc_t actual_target,
	// fetch stream
	output bp_pkg::pc_t fetch_pc,
	output logic fetch_valid,
	// oldest in-flight instruction
	output logic resolve_valid,
	output bp_pkg::pc_t resolve_pc,
	// redirect on mispredict
	output logic flush,
	output bp_pkg::pc_t redirect_pc
);

	import bp_pkg::*;

	// btb answer
	logic predict_taken;
	pc_t predict_target;

	// fetch to queue
	pc_t push_next;
	logic full;

	// queue to resolver
	logic not_empty;
	pc_t head_pc;
	pc_t head_next;
	logic pop;

	// resolver to btb
	logic train_en;
	pc_t train_pc;
	logic train_taken;
	pc_t train_target;

	branch_target_buffer #(
		.idx_bits(idx_bits)
	) btb0 (
		.clk(clk),
		.reset_n(reset_n),
		.lookup_pc(fetch_pc),
		.predict_taken(predict_taken),
		.predict_target(predict_target),
		.train_en(train_en),
		.train_pc(train_pc),
		.train_taken(train_taken),
		.train_target(train_target)
	);

	fetch_pc_gen pc_gen0 (
		.clk(clk),
		.reset_n(reset_n),
		.predict_taken(predict_taken),
		.predict_target(predict_target),
		.full(full),
		.flush(flush),
		.redirect_pc(redirect_pc),
		.fetch_pc(fetch_pc),
		.fetch_valid(fetch_valid),
		.push_next(push_next)
	);

	// fetch_valid doubles as the push strobe
	fetch_queue #(
		.queue_depth(queue_depth)
	) queue0 (
		.clk(clk),
		.reset_n(reset_n),
		.push(fetch_valid),
		.push_pc(fetch_pc),
		.push_next(push_next),
		.pop(pop),
		.flush(flush),
		.full(full),
		.not_empty(not_empty),
		.head_pc(head_pc),
		.head_next(head_next)
	);

	branch_resolver resolver0 (
		.resolve_en(resolve_en),
		.is_branch(is_branch),
		.actual_taken(actual_taken),
		.actual_target(actual_target),
		.head_pc(head_pc),
		.head_next(head_next),
		.pop(pop),
		.flush(flush),
		.redirect_pc(redirect_pc),
		.train_en(train_en),
		.train_pc(train_pc),
		.train_taken(train_taken),
		.train_target(train_target)
	);

	assign resolve_valid = not_empty;
	assign resolve_pc = head_pc;

endmodule

// File: branch_resolver.sv
`timescale 1ns/1ns

module branch_resolver (
	// outcome of the oldest in-flight instruction
	input logic resolve_en,
	input logic is_branch,
	input logic actual_taken,
	input bp_pkg::pc_t actual_target,
	// oldest queue entry
	input bp_pkg::pc_t head_pc,
	input bp_pkg::pc_t head_next,
	output logic pop,
	output logic flush,
	output bp_pkg::pc_t redirect_pc,
	// predictor training request
	output logic train_en,
	output bp_pkg::pc_t train_pc,
	output logic train_taken,
	output bp_pkg::pc_t train_target
);

	import bp_pkg::*;

	pc_t actual_next;
	logic mispredict;

	// where execution really goes after the head instruction
	assign actual_next = (is_branch && actual_taken) ? actual_target : head_pc + 1'b1;

	// compare with what fetch assumed when it queued the entry
	assign mispredict = (actual_next != head_next);

	// every resolve retires the head
	assign pop = resolve_en;

	// wrong path fetched, restart fetch at the real next pc
	assign flush = resolve_en && mispredict;
	assign redirect_pc = actual_next;

	// only branches touch the btb
	assign train_en = resolve_en && is_branch;
	assign train_pc = head_pc;
	assign train_taken = actual_taken;
	// target is stored even when not taken so a later taken resolve can use it
	assign train_target = actual_target;

endmodule

// File: branch_target_buffer.sv
`timescale 1ns/1ns

module branch_target_buffer #(
	parameter int idx_bits = 4
) (
	input logic clk,
	input logic reset_n,
	// lookup side, driven by the fetch pc
	input bp_pkg::pc_t lookup_pc,
	output logic predict_taken,
	output bp_pkg::pc_t predict_target,
	// training side, driven by the resolver
	input logic train_en,
	input bp_pkg::pc_t train_pc,
	input logic train_taken,
	input bp_pkg::pc_t train_target
);

	import bp_pkg::*;

	localparam int entries = 1 << idx_bits;
	// tag is whatever is left above the index bits
	localparam int tag_bits = word_width - idx_bits;

	// per-entry state
	logic [entries-1:0] valid_q;
	sat_cnt_t [entries-1:0] cnt_q;
	logic [tag_bits-1:0] tag_q [entries];
	pc_t target_q [entries];

	logic [idx_bits-1:0] lookup_idx;
	logic [tag_bits-1:0] lookup_tag;
	logic lookup_hit;

	logic [idx_bits-1:0] train_idx;
	logic [tag_bits-1:0] train_tag;
	logic train_hit;

	// split the lookup pc into index and tag
	assign lookup_idx = lookup_pc[idx_bits-1:0];
	assign lookup_tag = lookup_pc[word_width-1:idx_bits];
	assign lookup_hit = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);

	// taken only on a hit with the counter at weak taken or above
	assign predict_taken = lookup_hit && (cnt_q[lookup_idx] >= cnt_weak_taken);
	// target is only meaningful together with predict_taken
	assign predict_target = target_q[lookup_idx];

	// same split for the pc being trained
	assign train_idx = train_pc[idx_bits-1:0];
	assign train_tag = train_pc[word_width-1:idx_bits];
	assign train_hit = valid_q[train_idx] && (tag_q[train_idx] == train_tag);

	// valid bits and counters
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_q <= '0;
			cnt_q <= '0;
		end else if (train_en) begin
			valid_q[train_idx] <= 1'b1;
			if (!train_hit) begin
				// allocate, counter starts on the weak side of the outcome
				cnt_q[train_idx] <= train_taken ? cnt_weak_taken : cnt_weak_not_taken;
			end else if (train_taken) begin
				// count up, saturate at 3
				if (cnt_q[train_idx] != 2'd3) begin
					cnt_q[train_idx] <= cnt_q[train_idx] + 2'd1;
				end
			end else begin
				// count down, saturate at 0
				if (cnt_q[train_idx] != 2'd0) begin
					cnt_q[train_idx] <= cnt_q[train_idx] - 2'd1;
				end
			end
		end
	end

	// tags and targets
	// on a hit the tag is rewritten with the same value
	always_ff @(posedge clk) begin
		if (train_en) begin
			tag_q[train_idx] <= train_tag;
			target_q[train_idx] <= train_target;
		end
	end

endmodule

// File: fetch_pc_gen.sv
`timescale 1ns/1ns

module fetch_pc_gen (
	input logic clk,
	input logic reset_n,
	// btb answer for the current fetch pc
	input logic predict_taken,
	input bp_pkg::pc_t predict_target,
	// queue back-pressure
	input logic full,
	// redirect from the resolver
	input logic flush,
	input bp_pkg::pc_t redirect_pc,
	output bp_pkg::pc_t fetch_pc,
	output logic fetch_valid,
	output bp_pkg::pc_t push_next
);

	import bp_pkg::*;

	pc_t pc_q;
	pc_t next_pc;

	// predicted next pc, btb target or fall through
	assign next_pc = predict_taken ? predict_target : pc_q + 1'b1;

	// a fetch happens while the queue has room and no redirect is pending
	// this is also the queue push strobe
	assign fetch_valid = !full && !flush;

	assign fetch_pc = pc_q;
	// the prediction travels with the pc so the resolver can check it
	assign push_next = next_pc;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc_q <= '0;
		end else if (flush) begin
			// mispredict, restart at the actual next pc
			pc_q <= redirect_pc;
		end else if (fetch_valid) begin
			pc_q <= next_pc;
		end
		// otherwise hold under back-pressure
	end

endmodule

// File: fetch_queue.sv
`timescale 1ns/1ns

module fetch_queue #(
	parameter int queue_depth = 4
) (
	input logic clk,
	input logic reset_n,
	input logic push,
	input bp_pkg::pc_t push_pc,
	input bp_pkg::pc_t push_next,
	input logic pop,
	input logic flush,
	output logic full,
	output logic not_empty,
	output bp_pkg::pc_t head_pc,
	output bp_pkg::pc_t head_next
);

	import bp_pkg::*;

	// keep the pointers at least one bit wide for a depth of 1
	localparam int ptr_bits = (queue_depth > 1) ? $clog2(queue_depth) : 1;
	localparam int cnt_bits = $clog2(queue_depth + 1);
	localparam logic [ptr_bits-1:0] last_slot = ptr_bits'(queue_depth - 1);

	// payload storage, fetched pc and its predicted next pc
	pc_t pc_mem [queue_depth];
	pc_t next_mem [queue_depth];

	logic [ptr_bits-1:0] rd_ptr;
	logic [ptr_bits-1:0] wr_ptr;
	logic [cnt_bits-1:0] count;

	logic do_push;
	logic do_pop;

	assign full = (count == cnt_bits'(queue_depth));
	assign not_empty = (count != '0);

	// flush drops this cycle's push as well
	assign do_push = push && !full && !flush;
	assign do_pop = pop && not_empty;

	assign head_pc = pc_mem[rd_ptr];
	assign head_next = next_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			// everything in flight is on the wrong path
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
			end
			// push and pop together leave the count alone
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			pc_mem[wr_ptr] <= push_pc;
			next_mem[wr_ptr] <= push_next;
		end
	end

endmodule

// File: src.f
bp_pkg.sv
branch_target_buffer.sv
fetch_pc_gen.sv
fetch_queue.sv
branch_resolver.sv
branch_predict_top.sv
bp_assert.sv
bp_checker.sv
bp_tb.sv
